// File: src/xr_pkg.sv
package xr_pkg;

    // basic data and address words
    typedef logic [15:0] word_t;
    typedef logic [15:0] xr_addr_t;

    // region codes from xr address bits 15:14
    localparam logic [1:0] REG_REGION   = 2'b00;
    localparam logic [1:0] TILE_REGION  = 2'b01;
    localparam logic [1:0] COLOR_REGION = 2'b10;
    localparam logic [1:0] COPP_REGION  = 2'b11;

    // colour lookup tables
    localparam int COLOR_W = 8;
    typedef logic [COLOR_W-1:0] color_idx_t;

    // tile memory, top bit of the tile address picks the bank
    localparam int TILE_W      = 13;
    localparam int TILE_MAIN_W = 12;
    localparam int TILE2_W     = 10;
    typedef logic [TILE_W-1:0] tile_addr_t;

    // copper program memory
    localparam int COPP_W = 10;
    typedef logic [COPP_W-1:0] copp_addr_t;
    typedef logic [31:0] copp_word_t;

    // configuration register file
    localparam int CFG_REGS = 16;

    // per-region views of one xr address
    typedef struct packed {
        logic [1:0] region;
        logic [4:0] unused;
        logic       pf_b;
        color_idx_t idx;
    } color_view_t;

    typedef struct packed {
        logic [1:0]             region;
        logic                   unused;
        logic                   bank;
        logic [TILE_MAIN_W-1:0] offset;
    } tile_view_t;

    typedef struct packed {
        logic [1:0] region;
        logic [2:0] unused;
        copp_addr_t entry;
        // 0 selects the high word
        logic       half;
    } copp_view_t;

    typedef struct packed {
        logic [1:0] region;
        logic [6:0] unused;
        logic [6:0] num;
    } reg_view_t;

    typedef union packed {
        xr_addr_t    raw;
        color_view_t color;
        tile_view_t  tile;
        copp_view_t  copp;
        reg_view_t   regs;
    } xr_addr_u;

    // shared write bus to all storage blocks
    typedef struct packed {
        xr_addr_u addr;
        word_t    data;
    } xr_wr_t;

    // control words exported by the config registers
    typedef struct packed {
        word_t vid_ctrl;
        word_t vid_left;
        word_t pf_a_ctrl;
        word_t pf_b_ctrl;
    } cfg_out_t;

endpackage

// File: src/xr_mem_arb.sv
module xr_mem_arb (
    input  logic                clk,
    input  logic                rst_n_i,

    // host register interface
    input  logic                xr_sel_i,
    input  logic                xr_wr_i,
    input  xr_pkg::xr_addr_t    xr_addr_i,
    input  xr_pkg::word_t       xr_data_i,
    output logic                xr_ack_o,
    output xr_pkg::word_t       xr_data_o,

    // copper write port
    input  logic                copp_sel_i,
    input  xr_pkg::xr_addr_t    copp_addr_i,
    input  xr_pkg::word_t       copp_data_i,
    output logic                copp_ack_o,

    // video colour and tile reads
    input  logic                vid_color_sel_i,
    input  xr_pkg::color_idx_t  vid_color_a_addr_i,
    input  xr_pkg::color_idx_t  vid_color_b_addr_i,
    input  logic                vid_tile_sel_i,
    input  xr_pkg::tile_addr_t  vid_tile_addr_i,
    output xr_pkg::word_t       vid_tile_data_o,

    // copper program read
    input  logic                copp_prog_sel_i,
    input  xr_pkg::copp_addr_t  copp_prog_addr_i,

    // write bus and enables
    output xr_pkg::xr_wr_t      wr_o,
    output logic                color_a_we_o,
    output logic                color_b_we_o,
    output logic                tile_main_we_o,
    output logic                tile2_we_o,
    output logic                copp_hi_we_o,
    output logic                copp_lo_we_o,
    output logic                reg_we_o,

    // read addresses to storage
    output xr_pkg::color_idx_t  color_a_raddr_o,
    output xr_pkg::color_idx_t  color_b_raddr_o,
    output xr_pkg::tile_addr_t  tile_raddr_o,
    output xr_pkg::copp_addr_t  copp_raddr_o,
    output logic [3:0]          reg_raddr_o,

    // read data from storage
    input  xr_pkg::word_t       color_a_rdata_i,
    input  xr_pkg::word_t       color_b_rdata_i,
    input  xr_pkg::word_t       tile_main_rdata_i,
    input  xr_pkg::word_t       tile2_rdata_i,
    input  xr_pkg::word_t       reg_rdata_i,
    input  xr_pkg::copp_word_t  copp_rdata_i
);

    import xr_pkg::*;

    xr_addr_u   host_a;
    xr_addr_u   copp_a;
    xr_addr_u   wr_addr;
    word_t      wr_data;
    logic [1:0] host_region;
    logic [1:0] wr_region;
    logic       host_sub;
    logic       port_busy;
    logic       host_go;
    logic       copp_go;
    logic       we_any;

    // state for the ack cycle
    logic [1:0] host_region_q;
    logic       host_sub_q;
    logic       tile_bank_q;

    assign host_a = xr_addr_i;
    assign copp_a = copp_addr_i;

    // region field sits in the same place in every view
    assign host_region = host_a.regs.region;

    // host sub-select and read port contention per region
    always_comb begin
        host_sub  = 1'b0;
        port_busy = 1'b0;
        case (host_region)
            COLOR_REGION: begin
                host_sub  = host_a.color.pf_b;
                port_busy = vid_color_sel_i;
            end
            TILE_REGION: begin
                host_sub  = host_a.tile.bank;
                port_busy = vid_tile_sel_i;
            end
            COPP_REGION: begin
                host_sub  = host_a.copp.half;
                port_busy = copp_prog_sel_i;
            end
            default: begin
                host_sub  = 1'b0;
                port_busy = 1'b0;
            end
        endcase
    end

    // copper writes win, host waits while copper or a busy read port holds it off
    assign copp_go = copp_sel_i & ~copp_ack_o;
    assign host_go = xr_sel_i & ~xr_ack_o & ~copp_sel_i & ~(~xr_wr_i & port_busy);

    // write source follows the copper select
    assign wr_addr = copp_sel_i ? copp_a : host_a;
    assign wr_data = copp_sel_i ? copp_data_i : xr_data_i;
    assign wr_o.addr = wr_addr;
    assign wr_o.data = wr_data;

    assign we_any    = copp_go | (host_go & xr_wr_i);
    assign wr_region = wr_addr.regs.region;

    // per-block write enables
    always_comb begin
        color_a_we_o   = we_any & (wr_region == COLOR_REGION) & ~wr_addr.color.pf_b;
        color_b_we_o   = we_any & (wr_region == COLOR_REGION) & wr_addr.color.pf_b;
        tile_main_we_o = we_any & (wr_region == TILE_REGION) & ~wr_addr.tile.bank;
        tile2_we_o     = we_any & (wr_region == TILE_REGION) & wr_addr.tile.bank;
        copp_hi_we_o   = we_any & (wr_region == COPP_REGION) & ~wr_addr.copp.half;
        copp_lo_we_o   = we_any & (wr_region == COPP_REGION) & wr_addr.copp.half;
        reg_we_o       = we_any & (wr_region == REG_REGION);
    end

    // read addresses, video and copper program ports take precedence
    assign color_a_raddr_o = vid_color_sel_i ? vid_color_a_addr_i : host_a.color.idx;
    assign color_b_raddr_o = vid_color_sel_i ? vid_color_b_addr_i : host_a.color.idx;
    assign tile_raddr_o    = vid_tile_sel_i ? vid_tile_addr_i
                                            : {host_a.tile.bank, host_a.tile.offset};
    assign copp_raddr_o    = copp_prog_sel_i ? copp_prog_addr_i : host_a.copp.entry;
    // registers alias modulo 16
    assign reg_raddr_o     = host_a.regs.num[3:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xr_ack_o   <= 1'b0;
            copp_ack_o <= 1'b0;
        end else begin
            xr_ack_o   <= host_go;
            copp_ack_o <= copp_go;
        end
    end

    // bank of the tile read in flight selects the video tile output
    always_ff @(posedge clk) begin
        tile_bank_q <= tile_raddr_o[TILE_W-1];
        if (host_go) begin
            host_region_q <= host_region;
            host_sub_q    <= host_sub;
        end
    end

    assign vid_tile_data_o = tile_bank_q ? tile2_rdata_i : tile_main_rdata_i;

    // host read data in the ack cycle
    always_comb begin
        case (host_region_q)
            COLOR_REGION: xr_data_o = host_sub_q ? color_b_rdata_i : color_a_rdata_i;
            TILE_REGION:  xr_data_o = host_sub_q ? tile2_rdata_i : tile_main_rdata_i;
            COPP_REGION:  xr_data_o = host_sub_q ? copp_rdata_i[15:0] : copp_rdata_i[31:16];
            default:      xr_data_o = reg_rdata_i;
        endcase
    end

endmodule

// File: src/color_ram.sv
module color_ram (
    input  logic                clk,
    input  logic                we_i,
    input  xr_pkg::color_idx_t  waddr_i,
    input  xr_pkg::word_t       wdata_i,
    input  xr_pkg::color_idx_t  raddr_i,
    output xr_pkg::word_t       rdata_o
);

    import xr_pkg::*;

    // one lookup table, one entry per colour index
    word_t mem [2**COLOR_W];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: src/tile_ram.sv
module tile_ram #(
    parameter int AWIDTH = xr_pkg::TILE_MAIN_W
) (
    input  logic                clk,
    input  logic                we_i,
    input  logic [AWIDTH-1:0]   waddr_i,
    input  xr_pkg::word_t       wdata_i,
    input  logic [AWIDTH-1:0]   raddr_i,
    output xr_pkg::word_t       rdata_o
);

    import xr_pkg::*;

    word_t mem [2**AWIDTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // tile fetch data is ready the cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: src/copper_ram.sv
module copper_ram (
    input  logic                clk,
    input  logic                we_hi_i,
    input  logic                we_lo_i,
    input  xr_pkg::copp_addr_t  waddr_i,
    input  xr_pkg::word_t       wdata_i,
    input  xr_pkg::copp_addr_t  raddr_i,
    output xr_pkg::copp_word_t  rdata_o
);

    import xr_pkg::*;

    // instruction halves kept in separate arrays
    word_t mem_hi [2**COPP_W];
    word_t mem_lo [2**COPP_W];
    word_t rd_hi;
    word_t rd_lo;

    always_ff @(posedge clk) begin
        if (we_hi_i) begin
            mem_hi[waddr_i] <= wdata_i;
        end
        if (we_lo_i) begin
            mem_lo[waddr_i] <= wdata_i;
        end
    end

    // both halves fetched together
    always_ff @(posedge clk) begin
        rd_hi <= mem_hi[raddr_i];
        rd_lo <= mem_lo[raddr_i];
    end

    // high word in the upper bits
    assign rdata_o = {rd_hi, rd_lo};

endmodule

// File: src/xr_config_regs.sv
module xr_config_regs (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                we_i,
    input  logic [3:0]          waddr_i,
    input  xr_pkg::word_t       wdata_i,
    input  logic [3:0]          raddr_i,
    output xr_pkg::word_t       rdata_o,
    output xr_pkg::cfg_out_t    cfg_o
);

    import xr_pkg::*;

    word_t regs [CFG_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < CFG_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // readback for the host, valid in the ack cycle
    always_ff @(posedge clk) begin
        rdata_o <= regs[raddr_i];
    end

    // first four registers drive the video control outputs
    assign cfg_o.vid_ctrl  = regs[0];
    assign cfg_o.vid_left  = regs[1];
    assign cfg_o.pf_a_ctrl = regs[2];
    assign cfg_o.pf_b_ctrl = regs[3];

endmodule

// File: src/xr_subsys_top.sv
module xr_subsys_top (
    input  logic                clk,
    input  logic                rst_n_i,

    // host register interface
    input  logic                xr_sel_i,
    input  logic                xr_wr_i,
    input  xr_pkg::xr_addr_t    xr_addr_i,
    input  xr_pkg::word_t       xr_data_i,
    output logic                xr_ack_o,
    output xr_pkg::word_t       xr_data_o,

    // copper write port
    input  logic                copp_sel_i,
    input  xr_pkg::xr_addr_t    copp_addr_i,
    input  xr_pkg::word_t       copp_data_i,
    output logic                copp_ack_o,

    // video reads
    input  logic                vid_color_sel_i,
    input  xr_pkg::color_idx_t  vid_color_a_addr_i,
    input  xr_pkg::color_idx_t  vid_color_b_addr_i,
    output xr_pkg::word_t       vid_color_a_data_o,
    output xr_pkg::word_t       vid_color_b_data_o,
    input  logic                vid_tile_sel_i,
    input  xr_pkg::tile_addr_t  vid_tile_addr_i,
    output xr_pkg::word_t       vid_tile_data_o,

    // copper program read
    input  logic                copp_prog_sel_i,
    input  xr_pkg::copp_addr_t  copp_prog_addr_i,
    output xr_pkg::copp_word_t  copp_prog_data_o,

    output xr_pkg::cfg_out_t    cfg_o
);

    import xr_pkg::*;

    xr_wr_t     wr_bus;
    logic       color_a_we;
    logic       color_b_we;
    logic       tile_main_we;
    logic       tile2_we;
    logic       copp_hi_we;
    logic       copp_lo_we;
    logic       reg_we;
    color_idx_t color_a_raddr;
    color_idx_t color_b_raddr;
    tile_addr_t tile_raddr;
    copp_addr_t copp_raddr;
    logic [3:0] reg_raddr;
    word_t      tile_main_rdata;
    word_t      tile2_rdata;
    word_t      reg_rdata;

    xr_mem_arb arb0 (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .xr_sel_i           (xr_sel_i),
        .xr_wr_i            (xr_wr_i),
        .xr_addr_i          (xr_addr_i),
        .xr_data_i          (xr_data_i),
        .xr_ack_o           (xr_ack_o),
        .xr_data_o          (xr_data_o),
        .copp_sel_i         (copp_sel_i),
        .copp_addr_i        (copp_addr_i),
        .copp_data_i        (copp_data_i),
        .copp_ack_o         (copp_ack_o),
        .vid_color_sel_i    (vid_color_sel_i),
        .vid_color_a_addr_i (vid_color_a_addr_i),
        .vid_color_b_addr_i (vid_color_b_addr_i),
        .vid_tile_sel_i     (vid_tile_sel_i),
        .vid_tile_addr_i    (vid_tile_addr_i),
        .vid_tile_data_o    (vid_tile_data_o),
        .copp_prog_sel_i    (copp_prog_sel_i),
        .copp_prog_addr_i   (copp_prog_addr_i),
        .wr_o               (wr_bus),
        .color_a_we_o       (color_a_we),
        .color_b_we_o       (color_b_we),
        .tile_main_we_o     (tile_main_we),
        .tile2_we_o         (tile2_we),
        .copp_hi_we_o       (copp_hi_we),
        .copp_lo_we_o       (copp_lo_we),
        .reg_we_o           (reg_we),
        .color_a_raddr_o    (color_a_raddr),
        .color_b_raddr_o    (color_b_raddr),
        .tile_raddr_o       (tile_raddr),
        .copp_raddr_o       (copp_raddr),
        .reg_raddr_o        (reg_raddr),
        .color_a_rdata_i    (vid_color_a_data_o),
        .color_b_rdata_i    (vid_color_b_data_o),
        .tile_main_rdata_i  (tile_main_rdata),
        .tile2_rdata_i      (tile2_rdata),
        .reg_rdata_i        (reg_rdata),
        .copp_rdata_i       (copp_prog_data_o)
    );

    // playfield A and B lookup tables
    color_ram color_a0 (
        .clk     (clk),
        .we_i    (color_a_we),
        .waddr_i (wr_bus.addr.color.idx),
        .wdata_i (wr_bus.data),
        .raddr_i (color_a_raddr),
        .rdata_o (vid_color_a_data_o)
    );

    color_ram color_b0 (
        .clk     (clk),
        .we_i    (color_b_we),
        .waddr_i (wr_bus.addr.color.idx),
        .wdata_i (wr_bus.data),
        .raddr_i (color_b_raddr),
        .rdata_o (vid_color_b_data_o)
    );

    tile_ram #(.AWIDTH(TILE_MAIN_W)) tile_main0 (
        .clk     (clk),
        .we_i    (tile_main_we),
        .waddr_i (wr_bus.addr.tile.offset),
        .wdata_i (wr_bus.data),
        .raddr_i (tile_raddr[TILE_MAIN_W-1:0]),
        .rdata_o (tile_main_rdata)
    );

    // second bank only decodes the low offset bits
    tile_ram #(.AWIDTH(TILE2_W)) tile2_0 (
        .clk     (clk),
        .we_i    (tile2_we),
        .waddr_i (wr_bus.addr.tile.offset[TILE2_W-1:0]),
        .wdata_i (wr_bus.data),
        .raddr_i (tile_raddr[TILE2_W-1:0]),
        .rdata_o (tile2_rdata)
    );

    copper_ram copp0 (
        .clk     (clk),
        .we_hi_i (copp_hi_we),
        .we_lo_i (copp_lo_we),
        .waddr_i (wr_bus.addr.copp.entry),
        .wdata_i (wr_bus.data),
        .raddr_i (copp_raddr),
        .rdata_o (copp_prog_data_o)
    );

    xr_config_regs regs0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (reg_we),
        .waddr_i (wr_bus.addr.regs.num[3:0]),
        .wdata_i (wr_bus.data),
        .raddr_i (reg_raddr),
        .rdata_o (reg_rdata),
        .cfg_o   (cfg_o)
    );

endmodule

// File: bench/tb_xr_subsys.sv
module tb_xr_subsys;

    import xr_pkg::*;

    // one expected host acknowledge
    typedef struct packed {
        logic  is_read;
        word_t data;
    } host_exp_t;

    logic       clk;
    logic       rst_n_i;
    logic       xr_sel_i;
    logic       xr_wr_i;
    xr_addr_t   xr_addr_i;
    word_t      xr_data_i;
    logic       xr_ack_o;
    word_t      xr_data_o;
    logic       copp_sel_i;
    xr_addr_t   copp_addr_i;
    word_t      copp_data_i;
    logic       copp_ack_o;
    logic       vid_color_sel_i;
    color_idx_t vid_color_a_addr_i;
    color_idx_t vid_color_b_addr_i;
    word_t      vid_color_a_data_o;
    word_t      vid_color_b_data_o;
    logic       vid_tile_sel_i;
    tile_addr_t vid_tile_addr_i;
    word_t      vid_tile_data_o;
    logic       copp_prog_sel_i;
    copp_addr_t copp_prog_addr_i;
    copp_word_t copp_prog_data_o;
    cfg_out_t   cfg_o;

    // reference model of every region
    word_t color_a_m [2**COLOR_W];
    word_t color_b_m [2**COLOR_W];
    word_t tile_main_m [2**TILE_MAIN_W];
    word_t tile2_m [2**TILE2_W];
    word_t copp_hi_m [2**COPP_W];
    word_t copp_lo_m [2**COPP_W];
    word_t reg_m [CFG_REGS];

    host_exp_t   host_q [$];
    host_exp_t   host_e;
    int          copp_pending = 0;
    int          cyc = 0;
    int          host_ack_cyc;
    int          copp_ack_cyc;
    logic [31:0] rng_state;
    xr_addr_t    addr;
    xr_addr_t    addr2;
    word_t       rw;

    xr_subsys_top dut0 (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_error($sformatf("Fail at %0t: %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_error($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_copp(input string name, input copp_word_t exp, input copp_word_t act);
        if (act !== exp)
            report_error($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_cfg(input string name, input cfg_out_t exp, input cfg_out_t act);
        if (act !== exp)
            report_error($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function word_t rand16();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    // random address inside one region with a chosen sub-select
    function automatic xr_addr_t make_addr(input logic [1:0] region, input logic sub,
                                           input word_t r);
        xr_addr_u a;
        a.raw = r;
        a.regs.region = region;
        if (region == COLOR_REGION)
            a.color.pf_b = sub;
        else if (region == TILE_REGION)
            a.tile.bank = sub;
        else if (region == COPP_REGION)
            a.copp.half = sub;
        return a.raw;
    endfunction

    function automatic void model_write(input xr_addr_u a, input word_t d);
        case (a.regs.region)
            COLOR_REGION: begin
                if (a.color.pf_b)
                    color_b_m[a.color.idx] = d;
                else
                    color_a_m[a.color.idx] = d;
            end
            TILE_REGION: begin
                // second bank only keeps the low offset bits
                if (a.tile.bank)
                    tile2_m[a.tile.offset[TILE2_W-1:0]] = d;
                else
                    tile_main_m[a.tile.offset] = d;
            end
            COPP_REGION: begin
                if (a.copp.half)
                    copp_lo_m[a.copp.entry] = d;
                else
                    copp_hi_m[a.copp.entry] = d;
            end
            default: reg_m[a.regs.num[3:0]] = d;
        endcase
    endfunction

    // expected value of a host read at one xr address
    function automatic word_t ref_read(input xr_addr_u a);
        word_t v;
        case (a.regs.region)
            COLOR_REGION: v = a.color.pf_b ? color_b_m[a.color.idx] : color_a_m[a.color.idx];
            TILE_REGION:  v = a.tile.bank ? tile2_m[a.tile.offset[TILE2_W-1:0]]
                                          : tile_main_m[a.tile.offset];
            COPP_REGION:  v = a.copp.half ? copp_lo_m[a.copp.entry] : copp_hi_m[a.copp.entry];
            default:      v = reg_m[a.regs.num[3:0]];
        endcase
        return v;
    endfunction

    function automatic copp_word_t ref_copp(input copp_addr_t e);
        return {copp_hi_m[e], copp_lo_m[e]};
    endfunction

    function automatic cfg_out_t ref_cfg();
        cfg_out_t c;
        c.vid_ctrl  = reg_m[0];
        c.vid_left  = reg_m[1];
        c.pf_a_ctrl = reg_m[2];
        c.pf_b_ctrl = reg_m[3];
        return c;
    endfunction

    task automatic host_access(input logic wr, input xr_addr_t a, input word_t d);
        host_exp_t e;
        int n;
        e.is_read = ~wr;
        e.data    = wr ? 16'h0000 : ref_read(a);
        if (wr)
            model_write(a, d);
        host_q.push_back(e);
        xr_sel_i  = 1'b1;
        xr_wr_i   = wr;
        xr_addr_i = a;
        xr_data_i = d;
        n = 0;
        @(negedge clk);
        while (!xr_ack_o) begin
            n++;
            if (n >= 50)
                report_error("timeout: host access got no xr_ack_o within 50 cycles");
            @(negedge clk);
        end
        host_ack_cyc = cyc;
        @(posedge clk);
        #2;
        xr_sel_i = 1'b0;
        xr_wr_i  = 1'b0;
    endtask

    task automatic copp_write(input xr_addr_t a, input word_t d);
        int n;
        model_write(a, d);
        copp_pending++;
        copp_sel_i  = 1'b1;
        copp_addr_i = a;
        copp_data_i = d;
        n = 0;
        @(negedge clk);
        while (!copp_ack_o) begin
            n++;
            if (n >= 50)
                report_error("timeout: copper write got no copp_ack_o within 50 cycles");
            @(negedge clk);
        end
        copp_ack_cyc = cyc;
        @(posedge clk);
        #2;
        copp_sel_i = 1'b0;
    endtask

    // video ports return data one cycle after the address
    task automatic video_color_check(input color_idx_t ia, input color_idx_t ib);
        vid_color_sel_i    = 1'b1;
        vid_color_a_addr_i = ia;
        vid_color_b_addr_i = ib;
        @(posedge clk);
        @(negedge clk);
        check_word("vid_color_a_data_o", ref_read({COLOR_REGION, 5'b0, 1'b0, ia}),
                   vid_color_a_data_o);
        check_word("vid_color_b_data_o", ref_read({COLOR_REGION, 5'b0, 1'b1, ib}),
                   vid_color_b_data_o);
        @(posedge clk);
        #2;
        vid_color_sel_i = 1'b0;
    endtask

    task automatic video_tile_check(input tile_addr_t t);
        vid_tile_sel_i  = 1'b1;
        vid_tile_addr_i = t;
        @(posedge clk);
        @(negedge clk);
        check_word("vid_tile_data_o", ref_read({TILE_REGION, 1'b0, t}), vid_tile_data_o);
        @(posedge clk);
        #2;
        vid_tile_sel_i = 1'b0;
    endtask

    task automatic copp_prog_check(input copp_addr_t e);
        copp_prog_sel_i  = 1'b1;
        copp_prog_addr_i = e;
        @(posedge clk);
        @(negedge clk);
        check_copp("copp_prog_data_o", ref_copp(e), copp_prog_data_o);
        @(posedge clk);
        #2;
        copp_prog_sel_i = 1'b0;
    endtask

    // every ack must match one outstanding access
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (xr_ack_o && copp_ack_o)
                report_error("xr_ack_o and copp_ack_o were high in the same cycle");
            if (xr_ack_o) begin
                if (host_q.size() == 0)
                    report_error("xr_ack_o pulsed with no host access pending");
                host_e = host_q.pop_front();
                if (host_e.is_read)
                    check_word("xr_data_o", host_e.data, xr_data_o);
            end
            if (copp_ack_o) begin
                if (copp_pending == 0)
                    report_error("copp_ack_o pulsed with no copper write pending");
                copp_pending--;
            end
        end
    end

    initial begin
        clk                = 1'b0;
        rst_n_i            = 1'b0;
        xr_sel_i           = 1'b0;
        xr_wr_i            = 1'b0;
        xr_addr_i          = '0;
        xr_data_i          = '0;
        copp_sel_i         = 1'b0;
        copp_addr_i        = '0;
        copp_data_i        = '0;
        vid_color_sel_i    = 1'b0;
        vid_color_a_addr_i = '0;
        vid_color_b_addr_i = '0;
        vid_tile_sel_i     = 1'b0;
        vid_tile_addr_i    = '0;
        copp_prog_sel_i    = 1'b0;
        copp_prog_addr_i   = '0;
        rng_state          = 32'd15;
        for (int i = 0; i < CFG_REGS; i++) begin
            reg_m[i] = '0;
        end

        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_bit("xr_ack_o", 1'b0, xr_ack_o);
        check_bit("copp_ack_o", 1'b0, copp_ack_o);
        check_cfg("cfg_o", '0, cfg_o);
        @(posedge clk);
        #2;

        // host write then readback, every region and sub-select
        for (int i = 0; i < 48; i++) begin
            addr = make_addr(i[1:0], i[2], rand16());
            host_access(1'b1, addr, rand16());
            // register numbers alias modulo 16
            if (addr[15:14] == REG_REGION)
                addr[6:4] = addr[6:4] ^ 3'b101;
            host_access(1'b0, addr, 16'h0000);
        end

        // copper and host write in the same cycle
        for (int i = 0; i < 4; i++) begin
            addr  = make_addr(COPP_REGION, i[0], rand16());
            addr2 = make_addr(COLOR_REGION, i[1], rand16());
            fork
                copp_write(addr, rand16());
                host_access(1'b1, addr2, rand16());
            join
            if (copp_ack_cyc >= host_ack_cyc)
                report_error("host write was acknowledged before the copper write");
            host_access(1'b0, addr, 16'h0000);
            host_access(1'b0, addr2, 16'h0000);
        end

        // video and copper program reads of written locations
        for (int i = 0; i < 6; i++) begin
            addr  = make_addr(COLOR_REGION, 1'b0, rand16());
            addr2 = make_addr(COLOR_REGION, 1'b1, rand16());
            host_access(1'b1, addr, rand16());
            host_access(1'b1, addr2, rand16());
            video_color_check(addr[7:0], addr2[7:0]);
            addr = make_addr(TILE_REGION, i[0], rand16());
            host_access(1'b1, addr, rand16());
            video_tile_check(addr[12:0]);
            addr = make_addr(COPP_REGION, 1'b0, rand16());
            host_access(1'b1, addr, rand16());
            copp_write(addr | 16'h0001, rand16());
            copp_prog_check(addr[10:1]);
        end

        // host tile read held off by the video tile port
        addr = make_addr(TILE_REGION, 1'b1, rand16());
        host_access(1'b1, addr, rand16());
        rw = rand16();
        vid_tile_sel_i  = 1'b1;
        vid_tile_addr_i = rw[12:0];
        fork
            host_access(1'b0, addr, 16'h0000);
            begin
                repeat (6) begin
                    @(negedge clk);
                    check_bit("xr_ack_o", 1'b0, xr_ack_o);
                end
                @(posedge clk);
                #2;
                vid_tile_sel_i = 1'b0;
            end
        join

        // config registers 0 to 3 show up on cfg_o
        for (int i = 0; i < 4; i++) begin
            addr = make_addr(REG_REGION, 1'b0, rand16());
            addr[3:0] = i[3:0];
            host_access(1'b1, addr, rand16());
            @(negedge clk);
            check_cfg("cfg_o", ref_cfg(), cfg_o);
            @(posedge clk);
            #2;
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: all.f
src/xr_pkg.sv
src/xr_mem_arb.sv
src/color_ram.sv
src/tile_ram.sv
src/copper_ram.sv
src/xr_config_regs.sv
src/xr_subsys_top.sv
bench/tb_xr_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the XR memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_xr_subsys

result=$(./obj_dir/Vtb_xr_subsys 2>&1 || true)
printf '%s\n' "$result"

# pass only if the testbench printed its pass line
printf '%s\n' "$result" | grep -qx "Done: no errors"
